/* compile.f */
src/ahb_pkg.sv
src/axi_pkg.sv
src/axi_chan_reg.sv
src/ahb_slave_ctrl.sv
src/axi_write_ctrl.sv
src/axi_read_ctrl.sv
src/ahb_axi_bridge.sv
test/ahb_axi_bridge_asserts.sv
test/tb_ahb_axi_bridge.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; pass only if the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_ahb_axi_bridge -f compile.f &&
./obj_dir/Vtb_ahb_axi_bridge | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* src/ahb_axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

// AHB-Lite slave to AXI4 master bridge, single transfers only
module ahb_axi_bridge (
	input  logic                            HCLK,
	input  logic                            HRESETn,
	// AHB-Lite slave
	input  logic [ahb_pkg::HADDR_W-1:0]     HADDR,
	input  logic                            HWRITE,
	input  ahb_pkg::hsize_e                 HSIZE,
	input  ahb_pkg::htrans_e                HTRANS,
	input  logic [ahb_pkg::HDATA_W-1:0]     HWDATA,
	output logic                            HREADY,
	output logic                            HRESP,
	output logic [ahb_pkg::HDATA_W-1:0]     HRDATA,
	// AXI4 master
	output logic                            aw_valid_o,
	output axi_pkg::axi_ax_t                aw_o,
	input  logic                            aw_ready_i,
	output logic                            w_valid_o,
	output axi_pkg::axi_w_t                 w_o,
	input  logic                            w_ready_i,
	input  logic                            b_valid_i,
	input  axi_pkg::axi_resp_e              b_resp_i,
	output logic                            b_ready_o,
	output logic                            ar_valid_o,
	output axi_pkg::axi_ax_t                ar_o,
	input  logic                            ar_ready_i,
	input  logic                            r_valid_i,
	input  logic [axi_pkg::AXI_DATA_W-1:0]  r_data_i,
	input  axi_pkg::axi_resp_e              r_resp_i,
	output logic                            r_ready_o
);

	import ahb_pkg::*;
	import axi_pkg::*;

	ahb_cmd_t  cmd;
	logic      wr_start;
	logic      rd_start;
	logic      wr_done;
	logic      rd_done;
	axi_done_t wr_info;
	axi_done_t rd_info;
	axi_done_t done_info;

	// Only one path is busy, the idle one reports zero
	assign done_info.err  = wr_info.err | rd_info.err;
	assign done_info.data = wr_info.data | rd_info.data;

	ahb_slave_ctrl u_slave (
		.HCLK (HCLK), .HRESETn (HRESETn),
		.haddr_i (HADDR), .hwrite_i (HWRITE), .hsize_i (HSIZE), .htrans_i (HTRANS),
		.wr_done_i (wr_done), .rd_done_i (rd_done), .done_i (done_info),
		.hready_o (HREADY), .hresp_o (HRESP), .hrdata_o (HRDATA),
		.cmd_o (cmd), .wr_start_o (wr_start), .rd_start_o (rd_start)
	);

	axi_write_ctrl u_wr (
		.HCLK (HCLK), .HRESETn (HRESETn),
		.start_i (wr_start), .cmd_i (cmd), .hwdata_i (HWDATA),
		.aw_ready_i (aw_ready_i), .w_ready_i (w_ready_i),
		.b_valid_i (b_valid_i), .b_resp_i (b_resp_i),
		.aw_valid_o (aw_valid_o), .aw_o (aw_o), .w_valid_o (w_valid_o), .w_o (w_o),
		.b_ready_o (b_ready_o), .done_o (wr_done), .done_info_o (wr_info)
	);

	axi_read_ctrl u_rd (
		.HCLK (HCLK), .HRESETn (HRESETn),
		.start_i (rd_start), .cmd_i (cmd), .ar_ready_i (ar_ready_i),
		.r_valid_i (r_valid_i), .r_data_i (r_data_i), .r_resp_i (r_resp_i),
		.ar_valid_o (ar_valid_o), .ar_o (ar_o), .r_ready_o (r_ready_o),
		.done_o (rd_done), .done_info_o (rd_info)
	);

endmodule

`default_nettype wire

/* src/ahb_pkg.sv */
`default_nettype none

// AHB-Lite side encodings and the command handed to the AXI paths
package ahb_pkg;

	localparam int HADDR_W = 32; // HADDR width
	localparam int HDATA_W = 64; // HWDATA / HRDATA width

	// HTRANS encoding
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00, // No transfer
		HTRANS_BUSY   = 2'b01, // Burst pause, ignored
		HTRANS_NONSEQ = 2'b10, // First or single beat
		HTRANS_SEQ    = 2'b11  // Later burst beat
	} htrans_e;

	// HSIZE encoding
	// Only byte through doubleword fit the 64-bit bus
	typedef enum logic [2:0] {
		HSIZE_BYTE  = 3'b000,
		HSIZE_HALF  = 3'b001,
		HSIZE_WORD  = 3'b010,
		HSIZE_DWORD = 3'b011
	} hsize_e;

	// Captured address phase
	typedef struct packed {
		logic [HADDR_W-1:0] addr;  // HADDR at acceptance
		hsize_e             size;  // HSIZE at acceptance
		logic               write; // HWRITE at acceptance
	} ahb_cmd_t;

endpackage

`default_nettype wire

/* src/ahb_slave_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// AHB-Lite slave front end
// Captures one address phase at a time and stalls until the AXI path reports done
module ahb_slave_ctrl (
	input  logic                          HCLK,
	input  logic                          HRESETn,
	input  logic [ahb_pkg::HADDR_W-1:0]   haddr_i,
	input  logic                          hwrite_i,
	input  ahb_pkg::hsize_e               hsize_i,
	input  ahb_pkg::htrans_e              htrans_i,
	input  logic                          wr_done_i,  // B handshake
	input  logic                          rd_done_i,  // R handshake
	input  axi_pkg::axi_done_t            done_i,     // Merged report of both paths
	output logic                          hready_o,
	output logic                          hresp_o,
	output logic [ahb_pkg::HDATA_W-1:0]   hrdata_o,
	output ahb_pkg::ahb_cmd_t             cmd_o,      // Held for the whole transfer
	output logic                          wr_start_o,
	output logic                          rd_start_o
);

	import ahb_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE, // Ready for an address phase
		ST_WAIT, // AXI transaction in flight
		ST_ERR1, // First ERROR cycle, HREADY low
		ST_ERR2  // Second ERROR cycle, HREADY high
	} state_e;

	state_e state_q;
	state_e state_d;
	logic   accept;
	logic   done;

	assign done = wr_done_i | rd_done_i;

	// IDLE and BUSY never start anything
	assign accept = hready_o && (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

	// Response outputs straight from state
	assign hready_o = (state_q == ST_IDLE) || (state_q == ST_ERR2);
	assign hresp_o  = (state_q == ST_ERR1) || (state_q == ST_ERR2);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (accept) begin
					state_d = ST_WAIT;
				end
			end
			ST_WAIT: begin
				if (done) begin
					state_d = done_i.err ? ST_ERR1 : ST_IDLE; // Error takes two cycles
				end
			end
			ST_ERR1: state_d = ST_ERR2;
			ST_ERR2: state_d = accept ? ST_WAIT : ST_IDLE; // Master may go on here
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state_q    <= ST_IDLE;
			wr_start_o <= 1'b0;
			rd_start_o <= 1'b0;
			hrdata_o   <= '0;
		end else begin
			state_q    <= state_d;
			wr_start_o <= accept & hwrite_i;  // One cycle, data phase of a write
			rd_start_o <= accept & ~hwrite_i;
			if (rd_done_i) begin
				hrdata_o <= done_i.data; // Shown when HREADY rises
			end
		end
	end

	// Address phase capture
	always_ff @(posedge HCLK) begin
		if (accept) begin
			cmd_o.addr  <= haddr_i;
			cmd_o.size  <= hsize_i;
			cmd_o.write <= hwrite_i;
		end
	end

endmodule

`default_nettype wire

/* src/axi_chan_reg.sv */
`timescale 1ns/1ps
`default_nettype none

// Holding register for one AXI request channel
// Loaded at an edge, valid from the next cycle until the handshake edge
module axi_chan_reg #(
	parameter type payload_t = logic
) (
	input  logic     HCLK,
	input  logic     HRESETn,
	input  logic     load_i,    // Take a new payload at this edge
	input  payload_t payload_i,
	input  logic     ready_i,   // xREADY from the slave
	output logic     valid_o,   // xVALID to the slave
	output payload_t payload_o
);

	logic handshake;

	assign handshake = valid_o & ready_i;

	// Valid flag
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			valid_o <= 1'b0;
		end else if (load_i) begin
			valid_o <= 1'b1; // Next beat pending
		end else if (handshake) begin
			valid_o <= 1'b0; // Beat taken
		end
	end

	// Payload held stable while valid waits for ready
	always_ff @(posedge HCLK) begin
		if (load_i) begin
			payload_o <= payload_i;
		end
	end

endmodule

`default_nettype wire

/* src/axi_pkg.sv */
`default_nettype none

// AXI4 master side widths, response codes and channel payloads
package axi_pkg;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 64;
	localparam int AXI_STRB_W = AXI_DATA_W / 8; // One strobe bit per byte lane

	// xRESP encoding
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01, // Not expected, no exclusive access issued
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	// AW and AR beat
	// LEN, BURST and the rest are implied: single INCR beat
	typedef struct packed {
		logic [AXI_ADDR_W-1:0] addr;
		logic [2:0]            size; // Bytes per beat as log2
	} axi_ax_t;

	// W beat, always the last one
	typedef struct packed {
		logic [AXI_DATA_W-1:0] data;
		logic [AXI_STRB_W-1:0] strb;
	} axi_w_t;

	// Completion report from a path back to the AHB slave
	typedef struct packed {
		logic                  err;  // Response was not OKAY
		logic [AXI_DATA_W-1:0] data; // Read data, zero on writes
	} axi_done_t;

endpackage

`default_nettype wire

/* src/axi_read_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Read path
// One AR beat, then wait for R and pass RDATA back
module axi_read_ctrl (
	input  logic                            HCLK,
	input  logic                            HRESETn,
	input  logic                            start_i,
	input  ahb_pkg::ahb_cmd_t               cmd_i,
	input  logic                            ar_ready_i,
	input  logic                            r_valid_i,
	input  logic [axi_pkg::AXI_DATA_W-1:0]  r_data_i,
	input  axi_pkg::axi_resp_e              r_resp_i,
	output logic                            ar_valid_o,
	output axi_pkg::axi_ax_t                ar_o,
	output logic                            r_ready_o,
	output logic                            done_o,
	output axi_pkg::axi_done_t              done_info_o
);

	import axi_pkg::*;

	axi_ax_t ar_beat;
	logic    r_pend_q;

	assign ar_beat.addr = cmd_i.addr;
	assign ar_beat.size = cmd_i.size;

	axi_chan_reg #(
		.payload_t (axi_ax_t)
	) u_ar_reg (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.load_i    (start_i),
		.payload_i (ar_beat),
		.ready_i   (ar_ready_i),
		.valid_o   (ar_valid_o),
		.payload_o (ar_o)
	);

	// RREADY while the read is outstanding
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			r_pend_q <= 1'b0;
		end else if (start_i) begin
			r_pend_q <= 1'b1;
		end else if (done_o) begin
			r_pend_q <= 1'b0; // Single beat, so the first R ends it
		end
	end

	assign r_ready_o = r_pend_q;
	assign done_o    = r_valid_i & r_pend_q;

	// Zero outside the done cycle so the top can OR both reports
	assign done_info_o.err  = done_o && (r_resp_i != RESP_OKAY);
	assign done_info_o.data = done_o ? r_data_i : '0;

endmodule

`default_nettype wire

/* src/axi_write_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Write path
// One AW beat, one W beat, then wait for B
module axi_write_ctrl (
	input  logic                          HCLK,
	input  logic                          HRESETn,
	input  logic                          start_i,     // Data phase of an accepted write
	input  ahb_pkg::ahb_cmd_t             cmd_i,
	input  logic [ahb_pkg::HDATA_W-1:0]   hwdata_i,    // Sampled with start_i
	input  logic                          aw_ready_i,
	input  logic                          w_ready_i,
	input  logic                          b_valid_i,
	input  axi_pkg::axi_resp_e            b_resp_i,
	output logic                          aw_valid_o,
	output axi_pkg::axi_ax_t              aw_o,
	output logic                          w_valid_o,
	output axi_pkg::axi_w_t               w_o,
	output logic                          b_ready_o,
	output logic                          done_o,
	output axi_pkg::axi_done_t            done_info_o
);

	import ahb_pkg::*;
	import axi_pkg::*;

	localparam int OFFS_W = $clog2(AXI_STRB_W); // Byte lane index bits

	axi_ax_t               aw_beat;
	axi_w_t                w_beat;
	logic [AXI_STRB_W-1:0] size_mask; // 2^size ones from lane 0
	logic                  b_pend_q;

	always_comb begin
		case (cmd_i.size)
			HSIZE_BYTE:  size_mask = 8'h01;
			HSIZE_HALF:  size_mask = 8'h03;
			HSIZE_WORD:  size_mask = 8'h0f;
			HSIZE_DWORD: size_mask = 8'hff;
			default:     size_mask = 8'hff;
		endcase
	end

	always_comb begin
		aw_beat.addr = cmd_i.addr;
		aw_beat.size = cmd_i.size;
		w_beat.data  = hwdata_i;                               // Full bus, lanes picked by strb
		w_beat.strb  = size_mask << cmd_i.addr[OFFS_W-1:0]; // Shift to the address offset
	end

	axi_chan_reg #(
		.payload_t (axi_ax_t)
	) u_aw_reg (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.load_i    (start_i),
		.payload_i (aw_beat),
		.ready_i   (aw_ready_i),
		.valid_o   (aw_valid_o),
		.payload_o (aw_o)
	);

	axi_chan_reg #(
		.payload_t (axi_w_t)
	) u_w_reg (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.load_i    (start_i),
		.payload_i (w_beat),
		.ready_i   (w_ready_i),
		.valid_o   (w_valid_o),
		.payload_o (w_o)
	);

	// BREADY from load until the response arrives
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			b_pend_q <= 1'b0;
		end else if (start_i) begin
			b_pend_q <= 1'b1;
		end else if (done_o) begin
			b_pend_q <= 1'b0;
		end
	end

	assign b_ready_o = b_pend_q;
	assign done_o    = b_valid_i & b_pend_q;

	// Report is all zero outside the done cycle
	assign done_info_o.err  = done_o && (b_resp_i != RESP_OKAY);
	assign done_info_o.data = '0;

endmodule

`default_nettype wire

/* test/ahb_axi_bridge_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the bridge ports, bound into ahb_axi_bridge
module ahb_axi_bridge_asserts (
	input logic                        HCLK,
	input logic                        HRESETn,
	input logic [ahb_pkg::HADDR_W-1:0] HADDR,
	input ahb_pkg::hsize_e             HSIZE,
	input ahb_pkg::htrans_e            HTRANS,
	input logic                        HREADY,
	input logic                        HRESP,
	input logic                        aw_valid_o,
	input axi_pkg::axi_ax_t            aw_o,
	input logic                        aw_ready_i,
	input logic                        w_valid_o,
	input axi_pkg::axi_w_t             w_o,
	input logic                        w_ready_i,
	input logic                        ar_valid_o,
	input axi_pkg::axi_ax_t            ar_o,
	input logic                        ar_ready_i
);

	import ahb_pkg::*;

	logic accept;

	assign accept = HREADY && (HTRANS == HTRANS_NONSEQ || HTRANS == HTRANS_SEQ); // Address taken

	// Request payloads frozen under back-pressure
	aw_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
		aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
		else $error("AW valid or payload changed before the handshake");
	w_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
		w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
		else $error("W valid or payload changed before the handshake");
	ar_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
		ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
		else $error("AR valid or payload changed before the handshake");

	// Two-cycle ERROR response
	err_first: assert property (@(posedge HCLK) disable iff (!HRESETn)
		$rose(HRESP) |-> !HREADY)
		else $error("first ERROR cycle with HREADY high");
	err_second: assert property (@(posedge HCLK) disable iff (!HRESETn)
		$rose(HRESP) |=> HRESP)
		else $error("ERROR response shorter than two cycles");

	// AXI side idle whenever the AHB side is
	idle_axi: assert property (@(posedge HCLK) disable iff (!HRESETn)
		HREADY |-> !(aw_valid_o || w_valid_o || ar_valid_o))
		else $error("AXI valid high while HREADY is high");

	// Unaligned transfers are out of scope
	aligned: assert property (@(posedge HCLK) disable iff (!HRESETn)
		accept |-> (HADDR & ((32'd1 << HSIZE) - 32'd1)) == 32'd0)
		else $error("accepted address not aligned to HSIZE");

endmodule

bind ahb_axi_bridge ahb_axi_bridge_asserts u_asserts (
	.HCLK (HCLK), .HRESETn (HRESETn),
	.HADDR (HADDR), .HSIZE (HSIZE), .HTRANS (HTRANS), .HREADY (HREADY), .HRESP (HRESP),
	.aw_valid_o (aw_valid_o), .aw_o (aw_o), .aw_ready_i (aw_ready_i),
	.w_valid_o (w_valid_o), .w_o (w_o), .w_ready_i (w_ready_i),
	.ar_valid_o (ar_valid_o), .ar_o (ar_o), .ar_ready_i (ar_ready_i)
);

`default_nettype wire

/* test/tb_ahb_axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

// Directed testbench for the AHB-Lite to AXI4 bridge with an AXI slave memory model
module tb_ahb_axi_bridge;

	import ahb_pkg::*;
	import axi_pkg::*;

	localparam logic [31:0] BASE_ADDR = 32'h0000_4000;
	localparam int TIMEOUT_CYCLES = 4000; // About 125 transfers at up to 30 cycles plus reset

	logic               HCLK;
	logic               HRESETn;
	logic [HADDR_W-1:0] HADDR;
	logic               HWRITE;
	hsize_e             HSIZE;
	htrans_e            HTRANS;
	logic [HDATA_W-1:0] HWDATA;
	logic               HREADY;
	logic               HRESP;
	logic [HDATA_W-1:0] HRDATA;

	// AXI side driven by the slave model
	logic                  aw_ready = 1'b0;
	logic                  w_ready = 1'b0;
	logic                  ar_ready = 1'b0;
	logic                  b_valid = 1'b0;
	axi_resp_e             b_resp = RESP_OKAY;
	logic                  r_valid = 1'b0;
	logic [AXI_DATA_W-1:0] r_data = '0;
	axi_resp_e             r_resp = RESP_OKAY;
	logic                  aw_valid;
	logic                  w_valid;
	logic                  ar_valid;
	logic                  b_ready;
	logic                  r_ready;
	axi_ax_t               aw_beat;
	axi_w_t                w_beat;
	axi_ax_t               ar_beat;

	// Slave model state
	logic [63:0] mem [int unsigned];     // Model memory with WSTRB applied
	logic [63:0] exp_mem [int unsigned]; // Expected contents from the strobe rule
	axi_ax_t     last_aw = '0;
	axi_w_t      last_w = '0;
	axi_ax_t     last_ar = '0;
	logic        aw_seen = 1'b0;
	logic        w_seen = 1'b0;
	logic        ar_seen = 1'b0;
	logic        b_fire = 1'b0; // B taken at the coming edge
	logic        r_fire = 1'b0;
	int          aw_cnt = 0;
	int          w_cnt = 0;
	int          ar_cnt = 0;
	int          cycles = 0;
	logic        rand_ready;    // Random AXI readies when set
	axi_resp_e   b_resp_sel;
	axi_resp_e   r_resp_sel;
	int          n_wr;
	int          n_rd;

	ahb_axi_bridge u_dut (
		.HCLK (HCLK), .HRESETn (HRESETn),
		.HADDR (HADDR), .HWRITE (HWRITE), .HSIZE (HSIZE), .HTRANS (HTRANS), .HWDATA (HWDATA),
		.HREADY (HREADY), .HRESP (HRESP), .HRDATA (HRDATA),
		.aw_valid_o (aw_valid), .aw_o (aw_beat), .aw_ready_i (aw_ready),
		.w_valid_o (w_valid), .w_o (w_beat), .w_ready_i (w_ready),
		.b_valid_i (b_valid), .b_resp_i (b_resp), .b_ready_o (b_ready),
		.ar_valid_o (ar_valid), .ar_o (ar_beat), .ar_ready_i (ar_ready),
		.r_valid_i (r_valid), .r_data_i (r_data), .r_resp_i (r_resp), .r_ready_o (r_ready)
	);

	initial HCLK = 1'b0;
	always #5 HCLK = ~HCLK; // 10 ns period

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_ax(input string name, input axi_ax_t got, input axi_ax_t exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_w(input string name, input axi_w_t got, input axi_w_t exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_rdata(input string name, input logic [HDATA_W-1:0] got,
			input logic [HDATA_W-1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	// Pair is {HRESP, HREADY}
	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	// Flags are {AWVALID, WVALID, ARVALID, BREADY, RREADY}
	task automatic check_flags(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	// Unwritten words read back their own address
	function automatic logic [63:0] fill_word(input logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:3], 3'b000};
		return {~a, a};
	endfunction

	function automatic logic [63:0] expected_word(input logic [31:0] addr);
		int unsigned k;
		k = {3'b000, addr[31:3]};
		if (exp_mem.exists(k)) begin
			return exp_mem[k];
		end
		return fill_word(addr);
	endfunction

	// 2^size lanes starting at the byte offset within the doubleword
	function automatic logic [7:0] lane_strobe(input logic [31:0] addr, input hsize_e size);
		logic [7:0] s;
		int nbytes;
		int first;
		nbytes = 1 << int'(size);
		first = int'(addr[2:0]);
		for (int i = 0; i < 8; i++) begin
			s[i] = (i >= first) && (i < first + nbytes);
		end
		return s;
	endfunction

	// AXI slave model working on the falling edge
	always @(negedge HCLK) begin
		int unsigned k;
		logic [63:0] word;
		logic [31:0] rnd;
		if (!HRESETn) begin
			aw_ready = 1'b0;
			w_ready = 1'b0;
			ar_ready = 1'b0;
			b_valid = 1'b0;
			r_valid = 1'b0;
		end else begin
			if (b_fire) begin
				b_valid = 1'b0; // Taken at the last edge
				b_fire = 1'b0;
			end
			if (r_fire) begin
				r_valid = 1'b0;
				r_fire = 1'b0;
			end
			if (aw_seen && w_seen) begin // Both beats in so answer now
				if (b_resp_sel == RESP_OKAY) begin
					k = {3'b000, last_aw.addr[31:3]};
					word = mem.exists(k) ? mem[k] : fill_word(last_aw.addr);
					for (int i = 0; i < 8; i++) begin
						if (last_w.strb[i]) word[8*i +: 8] = last_w.data[8*i +: 8];
					end
					mem[k] = word;
				end
				b_valid = 1'b1;
				b_resp = b_resp_sel;
				aw_seen = 1'b0;
				w_seen = 1'b0;
			end
			if (ar_seen) begin
				k = {3'b000, last_ar.addr[31:3]};
				r_data = mem.exists(k) ? mem[k] : fill_word(last_ar.addr);
				r_valid = 1'b1;
				r_resp = r_resp_sel;
				ar_seen = 1'b0;
			end
			rnd = $urandom();
			aw_ready = rand_ready ? rnd[0] : 1'b1;
			w_ready = rand_ready ? rnd[1] : 1'b1;
			ar_ready = rand_ready ? rnd[2] : 1'b1;
			// Handshakes that the next rising edge will complete
			if (aw_valid && aw_ready) begin
				last_aw = aw_beat;
				aw_seen = 1'b1;
				aw_cnt++;
			end
			if (w_valid && w_ready) begin
				last_w = w_beat;
				w_seen = 1'b1;
				w_cnt++;
			end
			if (ar_valid && ar_ready) begin
				last_ar = ar_beat;
				ar_seen = 1'b1;
				ar_cnt++;
			end
			b_fire = b_valid && b_ready;
			r_fire = r_valid && r_ready;
		end
	end

	always @(posedge HCLK) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("timeout after %0d cycles, tests did not finish", cycles));
		end
	end

	// One AHB transfer from the address phase to the end of the data phase
	task automatic do_xfer(input logic wr, input htrans_e trans, input logic [31:0] addr,
			input hsize_e size, input logic [63:0] wdata, input logic exp_err);
		axi_ax_t     exp_ax;
		axi_w_t      exp_w;
		logic [7:0]  strb;
		logic [63:0] word;
		exp_ax.addr = addr;
		exp_ax.size = size;
		strb = lane_strobe(addr, size);
		exp_w.data = wdata;
		exp_w.strb = strb;
		@(negedge HCLK);
		if (!HREADY) fail_run("HREADY low at the start of an address phase");
		HADDR = addr;
		HWRITE = wr;
		HSIZE = size;
		HTRANS = trans;
		@(negedge HCLK);
		HTRANS = HTRANS_IDLE; // Data phase with no next address
		HWDATA = wdata;
		while (!HREADY && !HRESP) @(negedge HCLK);
		if (exp_err) begin
			check_resp("HRESP/HREADY", {HRESP, HREADY}, 2'b10);
			@(negedge HCLK);
			check_resp("HRESP/HREADY", {HRESP, HREADY}, 2'b11);
		end else begin
			check_resp("HRESP/HREADY", {HRESP, HREADY}, 2'b01);
		end
		if (wr) begin
			n_wr++;
			check_ax("aw", last_aw, exp_ax);
			check_w("w", last_w, exp_w);
			if (!exp_err) begin
				word = expected_word(addr);
				for (int i = 0; i < 8; i++) begin
					if (strb[i]) word[8*i +: 8] = wdata[8*i +: 8];
				end
				exp_mem[{3'b000, addr[31:3]}] = word;
			end
		end else begin
			n_rd++;
			check_ax("ar", last_ar, exp_ax);
			if (!exp_err) check_rdata("HRDATA", HRDATA, expected_word(addr));
		end
	endtask

	task automatic after_reset();
		for (int i = 0; i < 3; i++) begin
			@(negedge HCLK);
			check_resp("HRESP/HREADY", {HRESP, HREADY}, 2'b01);
			check_rdata("HRDATA", HRDATA, '0);
			check_flags("valid/ready", {aw_valid, w_valid, ar_valid, b_ready, r_ready}, 5'b00000);
		end
	endtask

	// Every aligned offset of every size in one doubleword per size
	task automatic write_all_offsets();
		for (int sz = 0; sz < 4; sz++) begin
			for (int off = 0; off < 8; off += (1 << sz)) begin
				do_xfer(1'b1, HTRANS_NONSEQ, BASE_ADDR + 32'(sz * 8 + off), hsize_e'(3'(sz)),
					{$urandom(), $urandom()}, 1'b0);
			end
		end
	endtask

	task automatic read_back();
		for (int sz = 0; sz < 4; sz++) begin
			do_xfer(1'b0, HTRANS_NONSEQ, BASE_ADDR + 32'(sz * 8), hsize_e'(3'(sz)), '0, 1'b0);
		end
		do_xfer(1'b0, HTRANS_NONSEQ, BASE_ADDR + 32'h100, HSIZE_DWORD, '0, 1'b0); // Never written
	endtask

	task automatic idle_busy_ignored();
		for (int i = 0; i < 8; i++) begin
			@(negedge HCLK);
			check_resp("HRESP/HREADY", {HRESP, HREADY}, 2'b01);
			check_flags("valid/ready", {aw_valid, w_valid, ar_valid, b_ready, r_ready}, 5'b00000);
			HADDR = BASE_ADDR + 32'(i * 8);
			HWRITE = i[0];
			HSIZE = HSIZE_DWORD;
			HTRANS = (i[0] && i < 7) ? HTRANS_BUSY : HTRANS_IDLE;
		end
		do_xfer(1'b0, HTRANS_NONSEQ, BASE_ADDR, HSIZE_DWORD, '0, 1'b0); // Still alive
	endtask

	task automatic error_responses();
		b_resp_sel = RESP_SLVERR;
		do_xfer(1'b1, HTRANS_NONSEQ, BASE_ADDR + 32'h20, HSIZE_WORD,
			64'h0123_4567_89ab_cdef, 1'b1);
		b_resp_sel = RESP_OKAY;
		do_xfer(1'b1, HTRANS_NONSEQ, BASE_ADDR + 32'h20, HSIZE_DWORD,
			64'hfeed_beef_0bad_f00d, 1'b0);
		r_resp_sel = RESP_SLVERR;
		do_xfer(1'b0, HTRANS_NONSEQ, BASE_ADDR + 32'h20, HSIZE_DWORD, '0, 1'b1);
		r_resp_sel = RESP_OKAY;
		do_xfer(1'b0, HTRANS_NONSEQ, BASE_ADDR + 32'h20, HSIZE_DWORD, '0, 1'b0);
	endtask

	// Mixed traffic over 16 doublewords with stalling readies
	task automatic random_stalls();
		logic [31:0] rnd;
		logic [31:0] addr;
		hsize_e      size;
		rand_ready = 1'b1;
		for (int n = 0; n < 100; n++) begin
			rnd = $urandom();
			size = hsize_e'({1'b0, rnd[1:0]});
			addr = BASE_ADDR + {25'd0, rnd[7:4], 3'd0};
			addr = addr + ({29'd0, rnd[10:8]} & ~((32'd1 << size) - 32'd1)); // Aligned offset
			do_xfer(rnd[2], rnd[3] ? HTRANS_SEQ : HTRANS_NONSEQ, addr, size,
				{$urandom(), $urandom()}, 1'b0);
		end
		rand_ready = 1'b0;
	endtask

	initial begin
		void'($urandom(25));
		HRESETn = 1'b0;
		HADDR = '0;
		HWRITE = 1'b0;
		HSIZE = HSIZE_BYTE;
		HTRANS = HTRANS_IDLE;
		HWDATA = '0;
		rand_ready = 1'b0;
		b_resp_sel = RESP_OKAY;
		r_resp_sel = RESP_OKAY;
		n_wr = 0;
		n_rd = 0;
		repeat (10) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;
		after_reset();
		write_all_offsets();
		read_back();
		idle_busy_ignored();
		error_responses();
		random_stalls();
		@(negedge HCLK);
		if (aw_cnt == n_wr && w_cnt == n_wr && ar_cnt == n_rd) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			fail_run("AXI beat count differs from the number of AHB transfers");
		end
	end

endmodule

`default_nettype wire
